//--- common/matBuf_consts.svh
//##############################
// Matrix buffer constants
// Matrix sizes and the widths derived from them
//##############################

`ifndef MATBUF_CONSTS_SVH
`define MATBUF_CONSTS_SVH

// Rows of A (M)
`define matRows 7

// Columns of B (N)
`define matCols 9

// Largest inner dimension (MAXK)
`define maxInner 8

// Bits per matrix element
`define dataWidth 12

// Holds K values up to maxInner
`define kWidth 4

// Bank depths cover the largest K
`define aAddrWidth ($clog2(`matRows * `maxInner))
`define bAddrWidth ($clog2(`matCols * `maxInner))

`endif

//--- common/matBufPkg.sv
//##############################
// Matrix buffer package
// Loader states and datapath types
//##############################

`include "matBuf_consts.svh"

package matBufPkg;

    // Loader FSM states
    typedef enum logic [1:0] {
        idle,
        storeA,
        storeB,
        loaded
    } loadState_e;

    // One matrix element, two's complement
    typedef logic signed [`dataWidth-1:0] dataWord_t;

    // Inner dimension K, 1 to maxInner
    typedef logic [`kWidth-1:0] kValue_t;

    // Bank addresses
    typedef logic [`aAddrWidth-1:0] aAddr_t;
    typedef logic [`bAddrWidth-1:0] bAddr_t;

endpackage

//--- rtl/bankMemory.sv
//##############################
// Bank memory
// Single-port RAM, registered read
//##############################

`timescale 1ns/100ps

`include "matBuf_consts.svh"

module bankMemory
    import matBufPkg::*;
#(
    parameter int addrWidth = `aAddrWidth
) (
    input  logic                 clk,
    input  logic                 writeEnable,
    input  logic [addrWidth-1:0] addr,
    input  dataWord_t            writeData,
    output dataWord_t            readData
);

    // Full power-of-two depth, upper words unused for small K
    dataWord_t mem [0:(2**addrWidth)-1];

    always_ff @(posedge clk) begin
        // Read one cycle after the address
        readData <= mem[addr];
        // Write lands at the same edge
        if (writeEnable) begin
            mem[addr] <= writeData;
        end
    end

endmodule

//--- inputMem/loadController.sv
//##############################
// Load controller
// Loader FSM, write counters, K register
// and bank port steering
//##############################

`timescale 1ns/100ps

`include "matBuf_consts.svh"

module loadController
    import matBufPkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // Stream handshake and side values
    input  logic    sValid,
    input  kValue_t sK,
    input  logic    sNewA,
    output logic    sReady,
    // Compute side
    output logic    matricesLoaded,
    input  logic    computeFinished,
    output kValue_t kOut,
    input  aAddr_t  aReadAddr,
    input  bAddr_t  bReadAddr,
    // Bank ports
    output aAddr_t  aAddr,
    output bAddr_t  bAddr,
    output logic    aWriteEnable,
    output logic    bWriteEnable
);

    loadState_e state;
    loadState_e nextState;

    // Write counters, next address in each bank
    aAddr_t aCount;
    bAddr_t bCount;

    // K latched from the first beat
    kValue_t kReg;

    logic accept;
    logic aLast;
    logic bLast;

    // Beat moves only when both sides agree
    assign accept = sValid && sReady;

    // Final addresses for the current K
    assign aLast = (aCount == aAddr_t'(`matRows * kReg - 1));
    assign bLast = (bCount == bAddr_t'(`matCols * kReg - 1));

    assign kOut = kReg;

    // Next state
    always_comb begin
        nextState = state;
        unique case (state)
            idle: begin
                // First beat picks the bank to start with
                if (accept) begin
                    nextState = sNewA ? storeA : storeB;
                end
            end
            storeA: begin
                if (accept && aLast) begin
                    nextState = storeB;
                end
            end
            storeB: begin
                if (accept && bLast) begin
                    nextState = loaded;
                end
            end
            loaded: begin
                // Compute engine hands the banks back
                if (computeFinished) begin
                    nextState = idle;
                end
            end
        endcase
    end

    // Handshake, steering and write enables
    always_comb begin
        sReady         = 1'b1;
        matricesLoaded = 1'b0;
        aAddr          = aCount;
        bAddr          = bCount;
        aWriteEnable   = 1'b0;
        bWriteEnable   = 1'b0;
        unique case (state)
            idle: begin
                // sNewA decides which bank gets address 0
                aWriteEnable = accept && sNewA;
                bWriteEnable = accept && !sNewA;
            end
            storeA: begin
                aWriteEnable = accept;
            end
            storeB: begin
                bWriteEnable = accept;
            end
            loaded: begin
                // Stream closed, banks serve the compute engine
                sReady         = 1'b0;
                matricesLoaded = 1'b1;
                aAddr          = aReadAddr;
                bAddr          = bReadAddr;
            end
        endcase
    end

    // State, counters and K
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= idle;
            aCount <= '0;
            bCount <= '0;
            kReg   <= '0;
        end else begin
            state <= nextState;
            unique case (state)
                idle: begin
                    if (accept) begin
                        kReg <= sK;
                        // Address 0 taken by this beat
                        if (sNewA) begin
                            aCount <= aCount + 1'b1;
                        end else begin
                            bCount <= bCount + 1'b1;
                        end
                    end
                end
                storeA: begin
                    if (accept) begin
                        // B starts at 0 after the last A word
                        if (aLast) begin
                            bCount <= '0;
                        end else begin
                            aCount <= aCount + 1'b1;
                        end
                    end
                end
                storeB: begin
                    if (accept && !bLast) begin
                        bCount <= bCount + 1'b1;
                    end
                end
                loaded: begin
                    // Rewind both banks for the next load
                    if (computeFinished) begin
                        aCount <= '0;
                        bCount <= '0;
                    end
                end
            endcase
        end
    end

endmodule

//--- inputMem/inputMem.sv
//##############################
// Matrix input buffer
// Stream loader with A and B banks
// served to the compute engine
//##############################

`timescale 1ns/100ps

`include "matBuf_consts.svh"

module inputMem
    import matBufPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // Producer stream
    input  dataWord_t sData,
    input  logic      sValid,
    input  kValue_t   sK,
    input  logic      sNewA,
    output logic      sReady,
    // Compute engine side
    output logic      matricesLoaded,
    input  logic      computeFinished,
    output kValue_t   kOut,
    input  aAddr_t    aReadAddr,
    input  bAddr_t    bReadAddr,
    output dataWord_t aData,
    output dataWord_t bData
);

    // Bank ports driven by the controller
    aAddr_t aAddr;
    bAddr_t bAddr;
    logic   aWriteEnable;
    logic   bWriteEnable;

    // Loader FSM and address steering
    loadController ctrl_i (
        .clk            (clk),
        .reset          (reset),
        .sValid         (sValid),
        .sK             (sK),
        .sNewA          (sNewA),
        .sReady         (sReady),
        .matricesLoaded (matricesLoaded),
        .computeFinished(computeFinished),
        .kOut           (kOut),
        .aReadAddr      (aReadAddr),
        .bReadAddr      (bReadAddr),
        .aAddr          (aAddr),
        .bAddr          (bAddr),
        .aWriteEnable   (aWriteEnable),
        .bWriteEnable   (bWriteEnable)
    );

    // Bank A, M x MAXK words
    // Stream data goes straight in, write enable picks the bank
    bankMemory #(
        .addrWidth(`aAddrWidth)
    ) bankA_i (
        .clk        (clk),
        .writeEnable(aWriteEnable),
        .addr       (aAddr),
        .writeData  (sData),
        .readData   (aData)
    );

    // Bank B, N x MAXK words
    bankMemory #(
        .addrWidth(`bAddrWidth)
    ) bankB_i (
        .clk        (clk),
        .writeEnable(bWriteEnable),
        .addr       (bAddr),
        .writeData  (sData),
        .readData   (bData)
    );

endmodule

//--- sim/clockGen.sv
//##############################
// Testbench clock and reset
//##############################

`timescale 1ns/100ps

module clockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset drops on a falling edge, like the other stimulus
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- sim/loadScoreboard.sv
//##############################
// Load scoreboard
// Models both banks and K, checks DUT outputs
//##############################

`timescale 1ns/100ps

`include "matBuf_consts.svh"

module loadScoreboard
    import matBufPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      sValid,
    input  logic      sReady,
    input  dataWord_t sData,
    input  kValue_t   sK,
    input  logic      sNewA,
    input  logic      matricesLoaded,
    input  logic      computeFinished,
    input  kValue_t   kOut,
    input  aAddr_t    aReadAddr,
    input  bAddr_t    bReadAddr,
    input  dataWord_t aData,
    input  dataWord_t bData,
    output int        mismatchCount,
    output int        failCount
);

    // Model banks, plus a flag for every word ever written
    dataWord_t modelA [0:(1 << `aAddrWidth)-1];
    dataWord_t modelB [0:(1 << `bAddrWidth)-1];
    bit        writtenA [0:(1 << `aAddrWidth)-1];
    bit        writtenB [0:(1 << `bAddrWidth)-1];

    kValue_t modelK;
    logic    modelNewA;
    logic    inLoad;
    int      beats;
    int      aWords;
    int      bIndex;
    logic    afterReset;
    logic    wasLoaded;
    logic    released;
    logic    expectLoaded;
    logic    readPending;
    aAddr_t  aPendAddr;
    bAddr_t  bPendAddr;
    int      mismatches = 0;
    int      failures = 0;

    assign mismatchCount = mismatches;
    assign failCount     = failures;

    task automatic reportMismatch(input string name, input int expected, input int actual);
        mismatches++;
        $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        failures++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // Samples at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (reset) begin
            afterReset   = 1'b1;
            inLoad       = 1'b0;
            wasLoaded    = 1'b0;
            released     = 1'b0;
            expectLoaded = 1'b0;
            readPending  = 1'b0;
        end else begin
            // First cycle out of reset must look idle
            if (afterReset && (sReady !== 1'b1 || matricesLoaded !== 1'b0 || kOut !== '0)) begin
                reportFailure("outputs not idle after reset");
            end
            afterReset = 1'b0;
            // Load ends the cycle after its final beat
            if (expectLoaded && (matricesLoaded !== 1'b1 || sReady !== 1'b0)) begin
                reportFailure("matricesLoaded not raised right after the final beat");
            end
            expectLoaded = 1'b0;
            // Read data belongs to the address of the previous cycle
            if (readPending && writtenA[aPendAddr] && aData !== modelA[aPendAddr]) begin
                reportMismatch("aData", modelA[aPendAddr], aData);
            end
            if (readPending && writtenB[bPendAddr] && bData !== modelB[bPendAddr]) begin
                reportMismatch("bData", modelB[bPendAddr], bData);
            end
            readPending = matricesLoaded;
            aPendAddr   = aReadAddr;
            bPendAddr   = bReadAddr;
            // Stream closed while the banks are served
            if (matricesLoaded && sReady !== 1'b0) begin
                reportFailure("sReady high while matrices are loaded");
            end
            if (released && (sReady !== 1'b1 || matricesLoaded !== 1'b0)) begin
                reportFailure("stream not reopened one cycle after computeFinished");
            end
            // Only computeFinished may end the loaded state
            if (wasLoaded && matricesLoaded !== 1'b1 && !released) begin
                reportFailure("matricesLoaded dropped without computeFinished");
            end
            released = matricesLoaded && computeFinished;
            // End of load, count of accepted beats
            if (matricesLoaded && !wasLoaded) begin
                if (beats != (modelNewA ? `matRows + `matCols : `matCols) * modelK) begin
                    reportMismatch("beat count",
                        (modelNewA ? `matRows + `matCols : `matCols) * modelK, beats);
                end
                inLoad = 1'b0;
            end
            if (matricesLoaded && kOut !== modelK) begin
                reportMismatch("kOut", modelK, kOut);
            end
            wasLoaded = matricesLoaded;
            // Accepted beat, the first one of a load latches K and newA
            if (sValid && sReady) begin
                if (!inLoad) begin
                    modelK    = sK;
                    modelNewA = sNewA;
                    beats     = 0;
                    inLoad    = 1'b1;
                end
                aWords = `matRows * modelK;
                if (modelNewA && beats < aWords) begin
                    modelA[beats]   = sData;
                    writtenA[beats] = 1'b1;
                end else begin
                    bIndex = beats - (modelNewA ? aWords : 0);
                    if (bIndex < (1 << `bAddrWidth)) begin
                        modelB[bIndex]   = sData;
                        writtenB[bIndex] = 1'b1;
                    end else begin
                        reportFailure("more beats accepted than bank B holds");
                    end
                end
                beats++;
                // Final beat of the load
                if (beats == (modelNewA ? `matRows + `matCols : `matCols) * modelK) begin
                    expectLoaded = 1'b1;
                end
            end
        end
    end

endmodule

//--- sim/tbInputMem.sv
//##############################
// Matrix input buffer testbench
// Random loads, read sweeps, timeout
//##############################

`timescale 1ns/100ps

`include "matBuf_consts.svh"

module tbInputMem
    import matBufPkg::*;
();

    localparam int rounds   = 8;
    localparam int gapOneIn = 4;
    // Room per round for a full load with gaps plus both sweeps
    localparam int cycleLimit = rounds * (4 * 128 + 2 * 72 + 20);

    logic        clk;
    logic        reset;
    dataWord_t   sData;
    logic        sValid;
    kValue_t     sK;
    logic        sNewA;
    logic        sReady;
    logic        matricesLoaded;
    logic        computeFinished;
    kValue_t     kOut;
    aAddr_t      aReadAddr;
    bAddr_t      bReadAddr;
    dataWord_t   aData;
    dataWord_t   bData;
    int          mismatchCount;
    int          failCount;
    int          cycleCount = 0;
    logic [31:0] lcgState = 32'hbaad3316;
    // K of each round, producer to consumer
    kValue_t     roundK [$];

    clockGen #(.period(40), .resetCycles(16)) clockGen_i (.clk(clk), .reset(reset));

    inputMem dut_i (
        .clk(clk), .reset(reset), .sData(sData), .sValid(sValid), .sK(sK),
        .sNewA(sNewA), .sReady(sReady), .matricesLoaded(matricesLoaded),
        .computeFinished(computeFinished), .kOut(kOut), .aReadAddr(aReadAddr),
        .bReadAddr(bReadAddr), .aData(aData), .bData(bData)
    );

    loadScoreboard scoreboard_i (
        .clk(clk), .reset(reset), .sValid(sValid), .sReady(sReady), .sData(sData),
        .sK(sK), .sNewA(sNewA), .matricesLoaded(matricesLoaded),
        .computeFinished(computeFinished), .kOut(kOut), .aReadAddr(aReadAddr),
        .bReadAddr(bReadAddr), .aData(aData), .bData(bData),
        .mismatchCount(mismatchCount), .failCount(failCount)
    );

    // LCG step, upper bits are the useful ones
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(input int limit);
        return int'((nextRand() >> 16) % limit);
    endfunction

    // Offer one beat, hold it until sReady takes it
    task automatic sendBeat(input dataWord_t word, input kValue_t k, input logic newA);
        logic taken;
        if (randBelow(gapOneIn) == 0) begin
            sValid = 1'b0;
            @(negedge clk);
        end
        sData  = word;
        sK     = k;
        sNewA  = newA;
        sValid = 1'b1;
        taken  = 1'b0;
        while (!taken) begin
            // sReady is settled here and holds up to the rising edge
            taken = sReady;
            @(negedge clk);
        end
    endtask

    task automatic produceRounds();
        kValue_t k;
        logic    newA;
        int      beatTotal;
        for (int r = 0; r < rounds; r++) begin
            k = kValue_t'(randBelow(`maxInner) + 1);
            // First round has to fill bank A
            newA = (r == 0) ? 1'b1 : logic'(randBelow(2));
            beatTotal = (newA ? `matRows + `matCols : `matCols) * k;
            roundK.push_back(k);
            for (int i = 0; i < beatTotal; i++) begin
                sendBeat(dataWord_t'(nextRand() >> 20), k, newA);
            end
        end
        sValid = 1'b0;
    endtask

    // Sweep both banks once per load, then hand them back
    task automatic serveRounds();
        kValue_t k;
        int      aWords;
        for (int r = 0; r < rounds; r++) begin
            while (!matricesLoaded) @(negedge clk);
            k = roundK.pop_front();
            aWords = `matRows * k;
            for (int i = 0; i < `matCols * k; i++) begin
                aReadAddr = aAddr_t'((i < aWords) ? i : aWords - 1);
                bReadAddr = bAddr_t'(i);
                @(negedge clk);
            end
            computeFinished = 1'b1;
            @(negedge clk);
            computeFinished = 1'b0;
        end
    endtask

    initial begin
        sData           = '0;
        sValid          = 1'b0;
        sK              = kValue_t'(1);
        sNewA           = 1'b0;
        computeFinished = 1'b0;
        aReadAddr       = '0;
        bReadAddr       = '0;
        @(negedge reset);
        @(negedge clk);
        fork
            produceRounds();
            serveRounds();
        join
        repeat (4) @(negedge clk);
        $display("Error counts: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Hang guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+common
common/matBufPkg.sv
rtl/bankMemory.sv
inputMem/loadController.sv
inputMem/inputMem.sv
sim/clockGen.sv
sim/loadScoreboard.sv
sim/tbInputMem.sv

//--- run.sh
#!/bin/sh
# Build the matrix input buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f compile.f \
    --top-module tbInputMem -o simInputMem

# The testbench ends with $finish, so the exit status stays zero
./obj_dir/simInputMem > sim.log 2>&1
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
